/* logic/token_engine_pkg.sv */
////////////////////
// bus widths and address shift
// pass phase and GLB owner encodings
////////////////////
`default_nettype none

package token_engine_pkg;

    localparam int ADDR_W         = 32;
    localparam int DATA_W         = 32;
    localparam int BYTE_W         = 8;
    localparam int BYTES_PER_WORD = 4;
    localparam int ADDR_SHIFT     = 2;  // word to byte address

    typedef enum logic [2:0] {
        PS_IDLE,
        PS_LOAD_WEIGHT,
        PS_INIT_FIFO,
        PS_PREHEAT,
        PS_NORMAL_LOOP,
        PS_DONE
    } pass_state_e;

    // who drives the single GLB port this cycle
    typedef enum logic [1:0] {
        SRC_NONE,
        SRC_WEIGHT,
        SRC_OPSUM,
        SRC_IFMAP
    } glb_src_e;

endpackage

`default_nettype wire

/* logic/pass_sequencer.sv */
////////////////////
// pass phase FSM
// phase levels, FIFO reset pulse, done pulse
////////////////////
`timescale 1ns/1ps
`default_nettype none

module pass_sequencer
    import token_engine_pkg::*;
(
    input  logic clk,
    input  logic arst_n_i,
    input  logic pass_start_i,
    input  logic weight_done_i,
    input  logic preheat_done_i,
    input  logic loop_done_i,
    output logic load_weight_o,
    output logic init_fifo_o,
    output logic preheat_o,
    output logic normal_loop_o,
    output logic ifmap_fifo_reset_o,
    output logic pass_done_o
);

    pass_state_e state_q;
    pass_state_e state_n;
    logic        fifo_rst_q;

    always_comb begin
        state_n = state_q;
        case (state_q)
            PS_IDLE:        if (pass_start_i) state_n = PS_LOAD_WEIGHT;
            PS_LOAD_WEIGHT: if (weight_done_i) state_n = PS_INIT_FIFO;
            PS_INIT_FIFO:   state_n = PS_PREHEAT;      // always a single cycle
            PS_PREHEAT:     if (preheat_done_i) state_n = PS_NORMAL_LOOP;
            PS_NORMAL_LOOP: if (loop_done_i) state_n = PS_DONE;
            PS_DONE:        state_n = PS_IDLE;
            default:        state_n = PS_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= PS_IDLE;
            fifo_rst_q <= 1'b0;
        end else begin
            state_q    <= state_n;
            fifo_rst_q <= (state_n == PS_INIT_FIFO); // high for the PS_INIT_FIFO cycle
        end
    end

    assign load_weight_o      = (state_q == PS_LOAD_WEIGHT);
    assign init_fifo_o        = (state_q == PS_INIT_FIFO);
    assign preheat_o          = (state_q == PS_PREHEAT);
    assign normal_loop_o      = (state_q == PS_NORMAL_LOOP);
    assign ifmap_fifo_reset_o = fifo_rst_q;
    assign pass_done_o        = (state_q == PS_DONE);

endmodule

`default_nettype wire

/* logic/weight_loader.sv */
////////////////////
// weight word fetch from the GLB
// byte unpacking with walking one-hot load enable
////////////////////
`timescale 1ns/1ps
`default_nettype none

module weight_loader
    import token_engine_pkg::*;
#(
    parameter  int NUM_FIFO   = 4,
    parameter  int KERNEL     = 3,
    localparam int NUM_WEIGHT = NUM_FIFO * KERNEL * KERNEL
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  load_weight_i,
    input  logic [ADDR_W-1:0]     weight_base_i,
    input  logic [DATA_W-1:0]     glb_read_data_i,
    input  logic                  wt_gnt_i,
    output logic                  wt_req_o,
    output logic [ADDR_W-1:0]     wt_addr_o,
    output logic [BYTE_W-1:0]     weight_in_o,
    output logic [NUM_WEIGHT-1:0] weight_load_en_o,
    output logic                  weight_done_o
);

    localparam int WEIGHT_WORDS = (NUM_WEIGHT + BYTES_PER_WORD - 1) / BYTES_PER_WORD;
    localparam int WORD_W       = $clog2(WEIGHT_WORDS + 1);
    localparam int SUB_W        = $clog2(BYTES_PER_WORD);

    logic [WORD_W-1:0]       word_q;     // words fully unpacked so far
    logic [SUB_W-1:0]        sub_q;      // byte within the current word
    logic                    unpack_q;
    logic                    done_q;
    logic [DATA_W-1:0]       shift_q;
    logic [WORD_W+SUB_W-1:0] byte_idx;
    logic                    last_byte;
    logic                    word_end;

    assign byte_idx  = {word_q, sub_q};
    assign last_byte = unpack_q && (byte_idx == (WORD_W + SUB_W)'(NUM_WEIGHT - 1));
    assign word_end  = unpack_q && ((sub_q == SUB_W'(BYTES_PER_WORD - 1)) || last_byte);

    // next word only once the previous one is shifted out
    assign wt_req_o  = load_weight_i && !unpack_q && (word_q < WORD_W'(WEIGHT_WORDS));
    assign wt_addr_o = weight_base_i + ADDR_W'(word_q);

    // byte 0 comes straight from the GLB, the rest from the shifter
    assign weight_in_o = (sub_q == '0) ? glb_read_data_i[BYTE_W-1:0] : shift_q[BYTE_W-1:0];

    always_comb begin
        weight_load_en_o = '0;
        if (unpack_q) weight_load_en_o[byte_idx] = 1'b1;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            word_q   <= '0;
            sub_q    <= '0;
            unpack_q <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            done_q <= last_byte;
            if (!load_weight_i) begin
                word_q   <= '0;
                sub_q    <= '0;
                unpack_q <= 1'b0;
            end else if (wt_gnt_i) begin
                unpack_q <= 1'b1;  // data shows up next cycle
            end else if (word_end) begin
                unpack_q <= 1'b0;
                sub_q    <= '0;
                word_q   <= word_q + 1'b1;
            end else if (unpack_q) begin
                sub_q <= sub_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (unpack_q) shift_q <= ((sub_q == '0) ? glb_read_data_i : shift_q) >> BYTE_W;
    end

    assign weight_done_o = done_q;

endmodule

`default_nettype wire

/* logic/fifo_ctrl.sv */
////////////////////
// ifmap push scheduling for preheat and normal loop
// opsum pop and GLB write per loop step
////////////////////
`timescale 1ns/1ps
`default_nettype none

module fifo_ctrl
    import token_engine_pkg::*;
#(
    parameter int NUM_FIFO = 4,
    parameter int KERNEL   = 3
) (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic                       preheat_i,
    input  logic                       normal_loop_i,
    input  logic [ADDR_W-1:0]          ifmap_base_i,
    input  logic [ADDR_W-1:0]          opsum_base_i,
    input  logic [7:0]                 out_c_i,
    input  logic [NUM_FIFO-1:0]        ifmap_fifo_full_i,
    input  logic [NUM_FIFO-1:0]        ifmap_gnt_i,
    input  logic [NUM_FIFO-1:0]        opsum_gnt_i,
    input  logic [DATA_W-1:0]          glb_read_data_i,
    input  logic [NUM_FIFO*DATA_W-1:0] opsum_fifo_pop_data_i,
    output logic [NUM_FIFO-1:0]        ifmap_req_o,
    output logic [NUM_FIFO*ADDR_W-1:0] ifmap_addr_o,
    output logic [NUM_FIFO-1:0]        opsum_req_o,
    output logic [NUM_FIFO*ADDR_W-1:0] opsum_addr_o,
    output logic [DATA_W-1:0]          opsum_data_o,
    output logic [NUM_FIFO-1:0]        ifmap_fifo_push_o,
    output logic [DATA_W-1:0]          ifmap_fifo_push_data_o,
    output logic [NUM_FIFO-1:0]        opsum_fifo_pop_o,
    output logic                       preheat_done_o,
    output logic                       loop_done_o
);

    localparam int CNT_W = $clog2(256 + KERNEL);  // up to out_c + KERNEL - 1 words

    logic [CNT_W-1:0]    wcnt_q [NUM_FIFO];       // ifmap words granted per FIFO
    logic [NUM_FIFO-1:0] pend_q;                  // read in flight, one-hot
    logic [NUM_FIFO-1:0] op_done_q;
    logic [7:0]          step_q;

    logic [CNT_W-1:0]    quota;
    logic [ADDR_W-1:0]   row_len;
    logic                last_step;
    logic                push_phase;
    logic                words_done;
    logic                step_end;

    assign row_len   = ADDR_W'(out_c_i) + ADDR_W'(KERNEL - 1);
    assign last_step = (step_q == out_c_i - 8'd1);
    assign quota     = preheat_i ? CNT_W'(KERNEL) : CNT_W'(KERNEL) + CNT_W'(step_q) + 1'b1;

    // in the loop, pushes of a step wait for all its opsums, none after the last one
    assign push_phase = preheat_i || (normal_loop_i && (&op_done_q) && !last_step);

    always_comb begin
        words_done   = ~|pend_q;
        opsum_data_o = '0;
        for (int k = 0; k < NUM_FIFO; k++) begin
            ifmap_req_o[k] = push_phase && (wcnt_q[k] < quota) && !ifmap_fifo_full_i[k];
            opsum_req_o[k] = normal_loop_i && !op_done_q[k];
            ifmap_addr_o[k*ADDR_W +: ADDR_W] = ifmap_base_i + ADDR_W'(k) * row_len
                                             + ADDR_W'(wcnt_q[k]);
            opsum_addr_o[k*ADDR_W +: ADDR_W] = opsum_base_i + ADDR_W'(k) * ADDR_W'(out_c_i)
                                             + ADDR_W'(step_q);
            if (wcnt_q[k] != quota) words_done = 1'b0;
            if (opsum_gnt_i[k]) opsum_data_o = opsum_fifo_pop_data_i[k*DATA_W +: DATA_W];
        end
    end

    assign step_end       = normal_loop_i && (&op_done_q) && (last_step || words_done);
    assign preheat_done_o = preheat_i && words_done;
    assign loop_done_o    = step_end && last_step;

    // pop in the grant cycle, push when the read data returns
    assign opsum_fifo_pop_o       = opsum_gnt_i;
    assign ifmap_fifo_push_o      = pend_q;
    assign ifmap_fifo_push_data_o = glb_read_data_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pend_q    <= '0;
            op_done_q <= '0;
            step_q    <= '0;
            for (int k = 0; k < NUM_FIFO; k++) wcnt_q[k] <= '0;
        end else begin
            pend_q <= ifmap_gnt_i;
            if (!preheat_i && !normal_loop_i) begin
                op_done_q <= '0;
                step_q    <= '0;
                for (int k = 0; k < NUM_FIFO; k++) wcnt_q[k] <= '0;
            end else begin
                for (int k = 0; k < NUM_FIFO; k++) begin
                    if (ifmap_gnt_i[k]) wcnt_q[k] <= wcnt_q[k] + 1'b1;
                end
                if (step_end && !last_step) begin
                    op_done_q <= '0;
                    step_q    <= step_q + 8'd1;
                end else begin
                    op_done_q <= op_done_q | opsum_gnt_i;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/glb_arbiter.sv */
////////////////////
// GLB port arbiter
// fixed priority weight, opsum, ifmap
// round-robin within opsum and ifmap FIFOs
////////////////////
`timescale 1ns/1ps
`default_nettype none

module glb_arbiter
    import token_engine_pkg::*;
#(
    parameter int NUM_FIFO = 4
) (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic                       wt_req_i,
    input  logic [ADDR_W-1:0]          wt_addr_i,
    input  logic [NUM_FIFO-1:0]        opsum_req_i,
    input  logic [NUM_FIFO*ADDR_W-1:0] opsum_addr_i,
    input  logic [DATA_W-1:0]          opsum_data_i,
    input  logic [NUM_FIFO-1:0]        ifmap_req_i,
    input  logic [NUM_FIFO*ADDR_W-1:0] ifmap_addr_i,
    output logic                       wt_gnt_o,
    output logic [NUM_FIFO-1:0]        opsum_gnt_o,
    output logic [NUM_FIFO-1:0]        ifmap_gnt_o,
    output logic                       glb_rd_o,
    output logic                       glb_wr_o,
    output logic [ADDR_W-1:0]          glb_addr_o,
    output logic [3:0]                 glb_web_o,
    output logic [DATA_W-1:0]          glb_write_data_o
);

    localparam int IDX_W = (NUM_FIFO > 1) ? $clog2(NUM_FIFO) : 1;

    glb_src_e            src;
    logic [NUM_FIFO-1:0] op_pick;
    logic [NUM_FIFO-1:0] if_pick;
    logic [IDX_W-1:0]    op_last_q;   // last opsum winner
    logic [IDX_W-1:0]    if_last_q;
    logic [IDX_W-1:0]    op_idx;
    logic [IDX_W-1:0]    if_idx;
    logic [ADDR_W-1:0]   word_addr;

    // first requester after the last winner, one-hot
    function automatic logic [NUM_FIFO-1:0] rr_pick(input logic [NUM_FIFO-1:0] req,
                                                    input logic [IDX_W-1:0]    last);
        logic [NUM_FIFO-1:0] gnt;
        logic                found;
        int                  idx;
        gnt   = '0;
        found = 1'b0;
        for (int i = 1; i <= NUM_FIFO; i++) begin
            idx = (int'(last) + i) % NUM_FIFO;
            if (req[idx] && !found) begin
                gnt[idx] = 1'b1;
                found    = 1'b1;
            end
        end
        return gnt;
    endfunction

    always_comb begin
        op_pick = rr_pick(opsum_req_i, op_last_q);
        if_pick = rr_pick(ifmap_req_i, if_last_q);
        if (wt_req_i)          src = SRC_WEIGHT;
        else if (|opsum_req_i) src = SRC_OPSUM;  // drain opsums before new ifmap reads
        else if (|ifmap_req_i) src = SRC_IFMAP;
        else                   src = SRC_NONE;
    end

    assign wt_gnt_o    = (src == SRC_WEIGHT);
    assign opsum_gnt_o = (src == SRC_OPSUM) ? op_pick : '0;
    assign ifmap_gnt_o = (src == SRC_IFMAP) ? if_pick : '0;

    always_comb begin
        op_idx    = op_last_q;
        if_idx    = if_last_q;
        word_addr = wt_gnt_o ? wt_addr_i : '0;
        for (int k = 0; k < NUM_FIFO; k++) begin
            if (op_pick[k]) op_idx = IDX_W'(k);
            if (if_pick[k]) if_idx = IDX_W'(k);
            if (opsum_gnt_o[k]) word_addr = opsum_addr_i[k*ADDR_W +: ADDR_W];
            if (ifmap_gnt_o[k]) word_addr = ifmap_addr_i[k*ADDR_W +: ADDR_W];
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            op_last_q <= IDX_W'(NUM_FIFO - 1);   // FIFO 0 goes first
            if_last_q <= IDX_W'(NUM_FIFO - 1);
        end else begin
            if (src == SRC_OPSUM) op_last_q <= op_idx;
            if (src == SRC_IFMAP) if_last_q <= if_idx;
        end
    end

    assign glb_rd_o         = (src == SRC_WEIGHT) || (src == SRC_IFMAP);
    assign glb_wr_o         = (src == SRC_OPSUM);
    assign glb_addr_o       = word_addr << ADDR_SHIFT;
    assign glb_web_o        = glb_wr_o ? 4'b1111 : 4'b0000;  // full word writes only
    assign glb_write_data_o = opsum_data_i;

endmodule

`default_nettype wire

/* logic/token_engine.sv */
////////////////////
// token engine top level
// sequencer, weight loader, FIFO controller and GLB arbiter
////////////////////
`timescale 1ns/1ps
`default_nettype none

module token_engine
    import token_engine_pkg::*;
#(
    parameter  int NUM_FIFO   = 4,
    parameter  int KERNEL     = 3,
    localparam int NUM_WEIGHT = NUM_FIFO * KERNEL * KERNEL
) (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic                       pass_start_i,
    input  logic [ADDR_W-1:0]          weight_base_i,
    input  logic [ADDR_W-1:0]          ifmap_base_i,
    input  logic [ADDR_W-1:0]          opsum_base_i,
    input  logic [7:0]                 out_c_i,
    input  logic [DATA_W-1:0]          glb_read_data_i,
    input  logic [NUM_FIFO-1:0]        ifmap_fifo_full_i,
    input  logic [NUM_FIFO*DATA_W-1:0] opsum_fifo_pop_data_i,
    output logic                       glb_rd_o,
    output logic                       glb_wr_o,
    output logic [ADDR_W-1:0]          glb_addr_o,
    output logic [3:0]                 glb_web_o,
    output logic [DATA_W-1:0]          glb_write_data_o,
    output logic [BYTE_W-1:0]          weight_in_o,
    output logic [NUM_WEIGHT-1:0]      weight_load_en_o,
    output logic                       ifmap_fifo_reset_o,
    output logic [NUM_FIFO-1:0]        ifmap_fifo_push_o,
    output logic [DATA_W-1:0]          ifmap_fifo_push_data_o,
    output logic [NUM_FIFO-1:0]        opsum_fifo_pop_o,
    output logic                       pass_done_o
);

    // phase levels and their done strobes
    logic load_weight;
    logic preheat;
    logic normal_loop;
    logic weight_done;
    logic preheat_done;
    logic loop_done;

    // requests and grants towards the arbiter
    logic                       wt_req;
    logic                       wt_gnt;
    logic [ADDR_W-1:0]          wt_addr;
    logic [NUM_FIFO-1:0]        ifmap_req;
    logic [NUM_FIFO-1:0]        ifmap_gnt;
    logic [NUM_FIFO*ADDR_W-1:0] ifmap_addr;
    logic [NUM_FIFO-1:0]        opsum_req;
    logic [NUM_FIFO-1:0]        opsum_gnt;
    logic [NUM_FIFO*ADDR_W-1:0] opsum_addr;
    logic [DATA_W-1:0]          opsum_data;

    pass_sequencer u_pass_sequencer (
        .clk                (clk),
        .arst_n_i           (arst_n_i),
        .pass_start_i       (pass_start_i),
        .weight_done_i      (weight_done),
        .preheat_done_i     (preheat_done),
        .loop_done_i        (loop_done),
        .load_weight_o      (load_weight),
        .init_fifo_o        (),             // FIFO controller clears itself between phases
        .preheat_o          (preheat),
        .normal_loop_o      (normal_loop),
        .ifmap_fifo_reset_o (ifmap_fifo_reset_o),
        .pass_done_o        (pass_done_o)
    );

    weight_loader #(
        .NUM_FIFO (NUM_FIFO),
        .KERNEL   (KERNEL)
    ) u_weight_loader (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .load_weight_i    (load_weight),
        .weight_base_i    (weight_base_i),
        .glb_read_data_i  (glb_read_data_i),
        .wt_gnt_i         (wt_gnt),
        .wt_req_o         (wt_req),
        .wt_addr_o        (wt_addr),
        .weight_in_o      (weight_in_o),
        .weight_load_en_o (weight_load_en_o),
        .weight_done_o    (weight_done)
    );

    fifo_ctrl #(
        .NUM_FIFO (NUM_FIFO),
        .KERNEL   (KERNEL)
    ) u_fifo_ctrl (
        .clk                    (clk),
        .arst_n_i               (arst_n_i),
        .preheat_i              (preheat),
        .normal_loop_i          (normal_loop),
        .ifmap_base_i           (ifmap_base_i),
        .opsum_base_i           (opsum_base_i),
        .out_c_i                (out_c_i),
        .ifmap_fifo_full_i      (ifmap_fifo_full_i),
        .ifmap_gnt_i            (ifmap_gnt),
        .opsum_gnt_i            (opsum_gnt),
        .glb_read_data_i        (glb_read_data_i),
        .opsum_fifo_pop_data_i  (opsum_fifo_pop_data_i),
        .ifmap_req_o            (ifmap_req),
        .ifmap_addr_o           (ifmap_addr),
        .opsum_req_o            (opsum_req),
        .opsum_addr_o           (opsum_addr),
        .opsum_data_o           (opsum_data),
        .ifmap_fifo_push_o      (ifmap_fifo_push_o),
        .ifmap_fifo_push_data_o (ifmap_fifo_push_data_o),
        .opsum_fifo_pop_o       (opsum_fifo_pop_o),
        .preheat_done_o         (preheat_done),
        .loop_done_o            (loop_done)
    );

    glb_arbiter #(
        .NUM_FIFO (NUM_FIFO)
    ) u_glb_arbiter (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .wt_req_i         (wt_req),
        .wt_addr_i        (wt_addr),
        .opsum_req_i      (opsum_req),
        .opsum_addr_i     (opsum_addr),
        .opsum_data_i     (opsum_data),
        .ifmap_req_i      (ifmap_req),
        .ifmap_addr_i     (ifmap_addr),
        .wt_gnt_o         (wt_gnt),
        .opsum_gnt_o      (opsum_gnt),
        .ifmap_gnt_o      (ifmap_gnt),
        .glb_rd_o         (glb_rd_o),
        .glb_wr_o         (glb_wr_o),
        .glb_addr_o       (glb_addr_o),
        .glb_web_o        (glb_web_o),
        .glb_write_data_o (glb_write_data_o)
    );

endmodule

`default_nettype wire

/* tests/token_engine_assert.sv */
////////////////////
// concurrent checks on GLB access
// weight enable and done pulse
////////////////////
`timescale 1ns/1ps
`default_nettype none

module token_engine_assert #(
    parameter int NUM_WEIGHT = 36
) (
    input wire logic                  clk,
    input wire logic                  arst_n_i,
    input wire logic                  glb_rd_i,
    input wire logic                  glb_wr_i,
    input wire logic [31:0]           glb_addr_i,
    input wire logic [NUM_WEIGHT-1:0] weight_load_en_i,
    input wire logic                  pass_done_i
);

    // one GLB port, so never read and write together
    rd_wr_excl: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(glb_rd_i && glb_wr_i))
        else $error("GLB read and write in the same cycle");

    load_en_onehot: assert property (@(posedge clk) disable iff (!arst_n_i)
        $onehot0(weight_load_en_i))
        else $error("weight_load_en_o has more than one bit set");

    done_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        pass_done_i |=> !pass_done_i)
        else $error("pass_done_o high for two cycles");

    addr_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
        (glb_rd_i || glb_wr_i) |-> (glb_addr_i[1:0] == 2'b00))
        else $error("GLB byte address not word aligned");

endmodule

bind token_engine token_engine_assert #(.NUM_WEIGHT(NUM_WEIGHT)) u_assert (
    .clk              (clk),
    .arst_n_i         (arst_n_i),
    .glb_rd_i         (glb_rd_o),
    .glb_wr_i         (glb_wr_o),
    .glb_addr_i       (glb_addr_o),
    .weight_load_en_i (weight_load_en_o),
    .pass_done_i      (pass_done_o)
);

`default_nettype wire

/* tests/tb_token_engine.sv */
////////////////////
// testbench for the token engine
// clock, reset, GLB and opsum FIFO models
// reference values, checks, timeout
////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_token_engine
    import token_engine_pkg::*;
();

    localparam int NUM_FIFO   = 4;
    localparam int KERNEL     = 3;
    localparam int NUM_WEIGHT = NUM_FIFO * KERNEL * KERNEL;
    localparam int WT_WORDS   = (NUM_WEIGHT + 3) / 4;
    localparam int MEM_WORDS  = 16384;

    logic clk = 1'b0;
    logic arst_n_i, pass_start_i;
    logic [ADDR_W-1:0] weight_base_i, ifmap_base_i, opsum_base_i;
    logic [7:0] out_c_i;
    logic [DATA_W-1:0] glb_read_data_i;
    logic [NUM_FIFO-1:0] ifmap_fifo_full_i;
    logic [NUM_FIFO*DATA_W-1:0] opsum_fifo_pop_data_i;
    logic glb_rd_o, glb_wr_o, ifmap_fifo_reset_o, pass_done_o;
    logic [ADDR_W-1:0] glb_addr_o;
    logic [DATA_W-1:0] glb_write_data_o, ifmap_fifo_push_data_o;
    logic [3:0] glb_web_o;
    logic [BYTE_W-1:0] weight_in_o;
    logic [NUM_WEIGHT-1:0] weight_load_en_o;
    logic [NUM_FIFO-1:0] ifmap_fifo_push_o, opsum_fifo_pop_o;

    logic [31:0] mem [MEM_WORDS];  // GLB contents, word addressed
    logic [31:0] rd_word;          // returned in the next cycle
    int wt_cnt, rst_cnt, wr_cnt, done_cnt, push_total, errors, fails, tests;
    int push_idx [NUM_FIFO];
    int pop_cnt [NUM_FIFO];
    int oc_list [5];
    int cycles, cycle_limit;
    bit bp_on;

    token_engine #(.NUM_FIFO(NUM_FIFO), .KERNEL(KERNEL)) u_dut (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] expected_value(input int kind, input int k, input int idx);
        logic [31:0] word;
        if (kind == 0) begin  // weight byte idx
            word = mem[int'(weight_base_i) + idx / 4];
            return (word >> (8 * (idx % 4))) & 32'hff;
        end else if (kind == 1) begin  // ifmap word idx of FIFO k
            return mem[int'(ifmap_base_i) + k * (int'(out_c_i) + KERNEL - 1) + idx];
        end
        return 32'hA000_0000 + 32'(k * 65536 + idx);  // opsum pop value
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("error %s: got %h, expected %h", name, got, exp);
        errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("failure: %s", msg);
        errors++;
    endtask

    // models drive on the falling edge, checks run just after
    always @(negedge clk) begin
        logic [31:0] exp_v;
        int b;
        int w;
        glb_read_data_i = rd_word;
        for (int k = 0; k < NUM_FIFO; k++) begin
            ifmap_fifo_full_i[k] = bp_on && (($urandom % 10) < 3);
            opsum_fifo_pop_data_i[k*32 +: 32] = 32'hA000_0000 + 32'(k * 65536 + pop_cnt[k]);
        end
        #1;
        if (arst_n_i) begin
            if (glb_rd_o) rd_word = mem[glb_addr_o[15:2]];
            if (|weight_load_en_o) begin
                b = 0;
                for (int i = 0; i < NUM_WEIGHT; i++) if (weight_load_en_o[i]) b = i;
                if (b != wt_cnt) report_mismatch("weight_load_en_o", 32'(b), 32'(wt_cnt));
                exp_v = expected_value(0, 0, wt_cnt);
                if (weight_in_o != exp_v[7:0])
                    report_mismatch("weight_in_o", 32'(weight_in_o), exp_v);
                wt_cnt++;
            end
            if (ifmap_fifo_reset_o) begin
                if (push_total != 0) report_failure("ifmap FIFO reset after a push");
                rst_cnt++;
            end
            for (int k = 0; k < NUM_FIFO; k++) begin
                if (ifmap_fifo_push_o[k]) begin
                    if (rst_cnt != 1)
                        report_failure("ifmap push without one FIFO reset before it");
                    if (push_idx[k] >= int'(out_c_i) + KERNEL - 1) begin
                        report_failure("extra ifmap push");
                    end else begin
                        exp_v = expected_value(1, k, push_idx[k]);
                        if (ifmap_fifo_push_data_o != exp_v)
                            report_mismatch("ifmap_fifo_push_data_o", ifmap_fifo_push_data_o,
                                            exp_v);
                    end
                    push_idx[k]++;
                    push_total++;
                end
            end
            if (glb_wr_o) begin
                w = -1;
                for (int k = 0; k < NUM_FIFO; k++) if (opsum_fifo_pop_o[k]) w = k;
                if (w < 0) begin
                    report_failure("GLB write without an opsum pop");
                end else begin
                    exp_v = (opsum_base_i + 32'(w * int'(out_c_i) + pop_cnt[w])) << 2;
                    if (glb_addr_o != exp_v) report_mismatch("glb_addr_o", glb_addr_o, exp_v);
                    exp_v = expected_value(2, w, pop_cnt[w]);
                    if (glb_write_data_o != exp_v)
                        report_mismatch("glb_write_data_o", glb_write_data_o, exp_v);
                end
                if (glb_web_o != 4'b1111) report_mismatch("glb_web_o", 32'(glb_web_o), 32'hf);
                mem[glb_addr_o[15:2]] = glb_write_data_o;
                wr_cnt++;
            end
            for (int k = 0; k < NUM_FIFO; k++) if (opsum_fifo_pop_o[k]) pop_cnt[k]++;
            if (pass_done_o) begin
                if (wr_cnt != NUM_FIFO * int'(out_c_i))
                    report_failure("pass done before all writes");
                done_cnt++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: run exceeded %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic finish_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("test %0d %s: passed", tests, name);
        end else begin
            $display("test %0d %s: failed", tests, name);
            fails++;
        end
    endtask

    task automatic check_idle_outputs();
        int errs_before;
        errs_before = errors;
        repeat (6) begin
            @(negedge clk);
            #2;
            if (glb_rd_o || glb_wr_o || ifmap_fifo_reset_o || pass_done_o)
                report_failure("control output high while idle");
            if (glb_web_o != 4'b0000) report_mismatch("glb_web_o", 32'(glb_web_o), 32'h0);
            if (weight_load_en_o != '0) report_failure("weight load enable high while idle");
            if (ifmap_fifo_push_o != '0 || opsum_fifo_pop_o != '0)
                report_failure("push or pop while idle");
        end
        finish_test("idle after reset", errs_before);
    endtask

    task automatic run_pass(input string name, input int oc, input bit bp, input bit rand_base);
        int errs_before;
        errs_before = errors;
        @(negedge clk);
        weight_base_i = rand_base ? 32'($urandom % 1024) : 32'd16;
        ifmap_base_i  = rand_base ? 32'(1024 + $urandom % 2048) : 32'd1200;
        opsum_base_i  = rand_base ? 32'(8192 + $urandom % 4096) : 32'd9000;
        out_c_i       = 8'(oc);
        bp_on         = bp;
        wt_cnt = 0;
        rst_cnt = 0;
        wr_cnt = 0;
        done_cnt = 0;
        push_total = 0;
        for (int k = 0; k < NUM_FIFO; k++) begin
            push_idx[k] = 0;
            pop_cnt[k]  = 0;
        end
        pass_start_i = 1'b1;
        @(negedge clk);
        pass_start_i = 1'b0;
        while (done_cnt == 0) @(posedge clk);
        bp_on = 1'b0;
        if (wt_cnt != NUM_WEIGHT) report_failure("wrong number of weight bytes");
        if (rst_cnt != 1) report_failure("ifmap FIFO reset not pulsed exactly once");
        for (int k = 0; k < NUM_FIFO; k++)
            if (push_idx[k] != oc + KERNEL - 1) report_failure("wrong number of ifmap pushes");
        if (wr_cnt != NUM_FIFO * oc) report_failure("wrong number of GLB writes");
        finish_test(name, errs_before);
    endtask

    initial begin
        void'($urandom(32'hea356497));
        arst_n_i = 1'b0;
        pass_start_i = 1'b0;
        weight_base_i = '0;
        ifmap_base_i = '0;
        opsum_base_i = '0;
        out_c_i = 8'd1;
        glb_read_data_i = '0;
        ifmap_fifo_full_i = '0;
        opsum_fifo_pop_data_i = '0;
        rd_word = '0;
        bp_on = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) mem[i] = $urandom;
        oc_list[0] = 4;
        for (int i = 1; i < 5; i++) oc_list[i] = 2 + int'($urandom % 11);
        cycle_limit = 0;
        for (int i = 0; i < 5; i++)
            cycle_limit += 20 * (WT_WORDS + NUM_FIFO * (oc_list[i] + KERNEL - 1)
                                 + NUM_FIFO * oc_list[i]);
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        check_idle_outputs();
        run_pass("basic pass", oc_list[0], 1'b0, 1'b0);
        run_pass("back-pressure", oc_list[1], 1'b1, 1'b1);
        run_pass("back-pressure random", oc_list[2], 1'b1, 1'b1);
        run_pass("back-to-back first", oc_list[3], 1'b0, 1'b1);
        run_pass("back-to-back second", oc_list[4], 1'b1, 1'b1);
        $display("tests %0d, failed %0d, errors %0d", tests, fails, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* token_engine.f */
logic/token_engine_pkg.sv
logic/pass_sequencer.sv
logic/weight_loader.sv
logic/fifo_ctrl.sv
logic/glb_arbiter.sv
logic/token_engine.sv
tests/token_engine_assert.sv
tests/tb_token_engine.sv

/* Makefile */
SIM      = verilator
TOP      = tb_token_engine
FILELIST = token_engine.f
FLAGS    = --binary --timing --assert -j 0 -Wno-fatal
BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = Simulation failed

.PHONY: run build lint clean

run: build
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
